// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_intf.sv
      - rtl/branch_table.sv
      - rtl/fetch_flow.sv
      - rtl/fetch_unit.sv
      - rtl/fetch_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/fetch_assertions.sv
      - sim/fetch_tb.sv

// ==== all.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_intf.sv
rtl/branch_table.sv
rtl/fetch_flow.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
sim/fetch_assertions.sv
sim/fetch_tb.sv

// ==== rtl/branch_table.sv ====
`default_nettype none

`include "fetch_consts.svh"

module branch_table (
    input wire logic clk,
    input wire logic rst,
    btb_if.tbl       lookup
);

    localparam int entries = 2 ** `FETCH_BTB_INDEX_WIDTH;
    localparam int idx_lo  = 2;
    localparam int tag_lo  = `FETCH_BTB_INDEX_WIDTH + 2;

    // Entry fields, written on a jump and read asynchronously
    fetch_pkg::pc_t      target_mem [entries];
    fetch_pkg::btb_tag_t tag_mem    [entries];
    logic                jump_mem   [entries];
    fetch_pkg::history_t hist_mem   [entries];
    logic [entries-1:0]  entry_valid;

    fetch_pkg::btb_index_t rd_index;
    fetch_pkg::btb_tag_t   rd_tag;
    fetch_pkg::btb_index_t wr_index;
    fetch_pkg::btb_tag_t   wr_tag;
    fetch_pkg::history_t   wr_history;

    function automatic logic counter_taken(input fetch_pkg::history_t h);
        return (h == fetch_pkg::strong_taken) || (h == fetch_pkg::taken);
    endfunction

    // Counter step for an entry that was predicted
    function automatic fetch_pkg::history_t advance(
        input fetch_pkg::history_t h,
        input logic                branched
    );
        fetch_pkg::history_t n;
        case (h)
            fetch_pkg::strong_taken:
                n = branched ? fetch_pkg::strong_taken : fetch_pkg::taken;
            fetch_pkg::taken:
                n = branched ? fetch_pkg::strong_taken : fetch_pkg::strong_not_taken;
            fetch_pkg::not_taken:
                n = branched ? fetch_pkg::strong_taken : fetch_pkg::strong_not_taken;
            default:
                n = branched ? fetch_pkg::not_taken : fetch_pkg::strong_not_taken;
        endcase
        return n;
    endfunction

    // Lookup side
    assign rd_index = lookup.lookup_pc[tag_lo-1:idx_lo];
    assign rd_tag   = lookup.lookup_pc[`FETCH_PC_WIDTH-1:tag_lo];

    assign lookup.hit    = entry_valid[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign lookup.target = target_mem[rd_index];

    // A miss reads as not taken, so no stale or unwritten counter leaks out
    assign lookup.history       = lookup.hit ? hist_mem[rd_index] : fetch_pkg::strong_not_taken;
    assign lookup.predict_taken = jump_mem[rd_index] || counter_taken(hist_mem[rd_index]);

    // Update side
    assign wr_index = lookup.upd_pc[tag_lo-1:idx_lo];
    assign wr_tag   = lookup.upd_pc[`FETCH_PC_WIDTH-1:tag_lo];

    always_comb begin
        if (lookup.upd_miss) begin
            // Fresh entry starts one step from the middle
            wr_history = lookup.upd_branched ? fetch_pkg::taken : fetch_pkg::not_taken;
        end else begin
            wr_history = advance(lookup.upd_history, lookup.upd_branched);
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.upd_valid) begin
            target_mem[wr_index] <= lookup.upd_target;
            tag_mem[wr_index]    <= wr_tag;
            jump_mem[wr_index]   <= lookup.upd_jumped;
            hist_mem[wr_index]   <= wr_history;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (lookup.upd_valid) begin
            entry_valid[wr_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Program counter width
`define FETCH_PC_WIDTH 32

// Target table index, taken from pc[6:2], giving 32 entries
`define FETCH_BTB_INDEX_WIDTH 5

// Pc bits above the index and the two low bits
`define FETCH_TAG_WIDTH 25

// Reset address of the first fetch
`define FETCH_START_ADDR 32'h0000_0000

`endif

// ==== rtl/fetch_flow.sv ====
`default_nettype none

module fetch_flow (
    input wire logic  clk,
    input wire logic  rst,
    fetch_cmd_if.flow cmd,
    output logic      mem_valid,
    input wire logic  mem_ready,
    output logic      enable
);

    // Bit 1 is the instruction command, bit 0 the memory request
    logic [1:0] valid_q;
    logic [1:0] ready;

    assign ready = {cmd.ready, mem_ready};

    // Every output is either empty or draining this cycle
    assign enable = &(~valid_q | ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            // New fetch goes out on both outputs together
            valid_q <= '1;
        end else begin
            // Drop only the flags whose transfer happened
            valid_q <= valid_q & ~ready;
        end
    end

    assign cmd.valid = valid_q[1];
    assign mem_valid = valid_q[0];

endmodule

`default_nettype wire

// ==== rtl/fetch_intf.sv ====
`default_nettype none

// Instruction command towards decode
interface fetch_cmd_if;
    logic                  valid;
    logic                  ready;
    fetch_pkg::pc_t        pc;
    fetch_pkg::pc_t        next_pc;
    fetch_pkg::jump_flag_t jump_flag;
    logic                  miss;
    fetch_pkg::history_t   history;

    // Payload source, valid flag owner and consumer
    modport src (output pc, next_pc, jump_flag, miss, history);
    modport flow (output valid, input ready);
    modport sink (input valid, pc, next_pc, jump_flag, miss, history, output ready);
endinterface

// Jump command from execute, a one-cycle strobe
interface jump_cmd_if;
    logic                valid;
    fetch_pkg::pc_t      current_pc;
    fetch_pkg::pc_t      actual_next_pc;
    logic                update_pc;
    logic                jumped;
    logic                branched;
    logic                miss;
    fetch_pkg::history_t history;

    modport src (
        output valid, current_pc, actual_next_pc, update_pc,
        output jumped, branched, miss, history
    );
    modport sink (
        input valid, current_pc, actual_next_pc, update_pc,
        input jumped, branched, miss, history
    );
endinterface

// Branch target table lookup and update
interface btb_if;
    // Lookup, answered combinationally
    fetch_pkg::pc_t      lookup_pc;
    logic                hit;
    fetch_pkg::pc_t      target;
    logic                predict_taken;
    fetch_pkg::history_t history;

    // Update, written at the next edge
    logic                upd_valid;
    fetch_pkg::pc_t      upd_pc;
    fetch_pkg::pc_t      upd_target;
    logic                upd_jumped;
    logic                upd_branched;
    logic                upd_miss;
    fetch_pkg::history_t upd_history;

    modport client (
        output lookup_pc,
        input hit, target, predict_taken, history,
        output upd_valid, upd_pc, upd_target, upd_jumped,
        output upd_branched, upd_miss, upd_history
    );
    modport tbl (
        input lookup_pc,
        output hit, target, predict_taken, history,
        input upd_valid, upd_pc, upd_target, upd_jumped,
        input upd_branched, upd_miss, upd_history
    );
endinterface

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

    // Instruction address
    typedef logic [`FETCH_PC_WIDTH-1:0] pc_t;

    // Target table addressing
    typedef logic [`FETCH_BTB_INDEX_WIDTH-1:0] btb_index_t;
    typedef logic [`FETCH_TAG_WIDTH-1:0] btb_tag_t;

    // Redirect generation, wraps after four redirects
    typedef logic [1:0] jump_flag_t;

    // Two-bit branch history counter
    typedef enum logic [1:0] {
        strong_taken     = 2'd0,
        taken            = 2'd1,
        not_taken        = 2'd2,
        strong_not_taken = 2'd3
    } history_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_top.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_top #(
    parameter fetch_pkg::pc_t start_addr = `FETCH_START_ADDR
) (
    input wire logic              clk,
    input wire logic              rst,

    // Instruction command to decode
    output logic                  cmd_valid,
    input wire logic              cmd_ready,
    output fetch_pkg::pc_t        cmd_pc,
    output fetch_pkg::pc_t        cmd_next_pc,
    output fetch_pkg::jump_flag_t cmd_jump_flag,
    output logic                  cmd_miss,
    output fetch_pkg::history_t   cmd_history,

    // Instruction memory read request
    output logic                  mem_valid,
    input wire logic              mem_ready,
    output fetch_pkg::pc_t        mem_addr,

    // Jump command from execute
    input wire logic              jump_valid,
    input wire fetch_pkg::pc_t    jump_current_pc,
    input wire fetch_pkg::pc_t    jump_actual_next_pc,
    input wire logic              jump_update_pc,
    input wire logic              jump_jumped,
    input wire logic              jump_branched,
    input wire logic              jump_miss,
    input var fetch_pkg::history_t jump_history
);

    fetch_cmd_if cmd ();
    jump_cmd_if  jump ();
    btb_if       btb ();

    logic enable;

    // Decode side of the command stream
    assign cmd.ready     = cmd_ready;
    assign cmd_valid     = cmd.valid;
    assign cmd_pc        = cmd.pc;
    assign cmd_next_pc   = cmd.next_pc;
    assign cmd_jump_flag = cmd.jump_flag;
    assign cmd_miss      = cmd.miss;
    assign cmd_history   = cmd.history;

    // Execute side of the jump stream
    assign jump.valid          = jump_valid;
    assign jump.current_pc     = jump_current_pc;
    assign jump.actual_next_pc = jump_actual_next_pc;
    assign jump.update_pc      = jump_update_pc;
    assign jump.jumped         = jump_jumped;
    assign jump.branched       = jump_branched;
    assign jump.miss           = jump_miss;
    assign jump.history        = jump_history;

    fetch_flow u_flow (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .enable    (enable)
    );

    fetch_unit #(
        .start_addr (start_addr)
    ) u_unit (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .cmd      (cmd),
        .jump     (jump),
        .btb      (btb),
        .mem_addr (mem_addr)
    );

    branch_table u_table (
        .clk    (clk),
        .rst    (rst),
        .lookup (btb)
    );

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_unit #(
    parameter fetch_pkg::pc_t start_addr = `FETCH_START_ADDR
) (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       enable,
    fetch_cmd_if.src       cmd,
    jump_cmd_if.sink       jump,
    btb_if.client          btb,
    output fetch_pkg::pc_t mem_addr
);

    fetch_pkg::pc_t        pc_q;
    fetch_pkg::pc_t        next_pc;
    fetch_pkg::jump_flag_t jump_flag_q;
    logic                  miss_q;
    fetch_pkg::history_t   history_q;
    logic                  redirect;

    assign redirect = jump.valid && jump.update_pc;

    // Predict from the pc currently on the outputs
    assign btb.lookup_pc = pc_q;

    always_comb begin
        if (btb.hit && btb.predict_taken) begin
            next_pc = btb.target;
        end else begin
            next_pc = pc_q + fetch_pkg::pc_t'(4);
        end
    end

    // Pc and redirect generation
    always_ff @(posedge clk) begin
        if (rst) begin
            // First enabled edge steps onto start_addr
            pc_q        <= start_addr - fetch_pkg::pc_t'(4);
            jump_flag_q <= '0;
        end else if (redirect) begin
            // Redirect wins over a stall or a normal advance
            pc_q        <= jump.actual_next_pc;
            jump_flag_q <= jump_flag_q + 1'b1;
        end else if (enable) begin
            pc_q <= next_pc;
        end
    end

    // Prediction payload follows the pc on each fetch
    always_ff @(posedge clk) begin
        if (enable) begin
            miss_q    <= !btb.hit;
            history_q <= btb.history;
        end
    end

    // Every jump trains the table
    assign btb.upd_valid    = jump.valid;
    assign btb.upd_pc       = jump.current_pc;
    assign btb.upd_target   = jump.actual_next_pc;
    assign btb.upd_jumped   = jump.jumped;
    assign btb.upd_branched = jump.branched;
    assign btb.upd_miss     = jump.miss;
    assign btb.upd_history  = jump.history;

    assign cmd.pc        = pc_q;
    assign cmd.next_pc   = next_pc;
    assign cmd.jump_flag = jump_flag_q;
    assign cmd.miss      = miss_q;
    assign cmd.history   = history_q;

    assign mem_addr = pc_q;

endmodule

`default_nettype wire

// ==== sim/fetch_assertions.sv ====
`default_nettype none

module fetch_assertions (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic           cmd_valid,
    input wire logic           cmd_ready,
    input wire fetch_pkg::pc_t cmd_pc,
    input wire logic           mem_valid,
    input wire logic           mem_ready,
    input wire fetch_pkg::pc_t mem_addr,
    input wire logic           jump_valid,
    input wire logic           jump_update_pc
);

    logic redirect;

    assign redirect = jump_valid && jump_update_pc;

    // Nothing is offered after a reset edge
    reset_quiet: assert property (@(posedge clk) rst |=> !cmd_valid && !mem_valid)
        else $error("valid high after a reset edge");

    // A pending fetch waits for its own ready
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready && !redirect |=> cmd_valid)
        else $error("cmd_valid dropped without cmd_ready");

    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready && !redirect |=> mem_valid)
        else $error("mem_valid dropped without mem_ready");

    // Stalled payload holds unless redirected
    cmd_pc_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready && !redirect |=> $stable(cmd_pc))
        else $error("cmd_pc changed while stalled");

    mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready && !redirect |=> $stable(mem_addr))
        else $error("mem_addr changed while stalled");

endmodule

bind fetch_top fetch_assertions u_assertions (
    .clk            (clk),
    .rst            (rst),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_pc         (cmd_pc),
    .mem_valid      (mem_valid),
    .mem_ready      (mem_ready),
    .mem_addr       (mem_addr),
    .jump_valid     (jump_valid),
    .jump_update_pc (jump_update_pc)
);

`default_nettype wire

// ==== sim/fetch_tb.sv ====
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;

    localparam fetch_pkg::pc_t start_addr = `FETCH_START_ADDR;
    localparam int num_cycles = 2000;
    localparam int entries = 2 ** `FETCH_BTB_INDEX_WIDTH;

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    logic                  cmd_ready;
    fetch_pkg::pc_t        cmd_pc;
    fetch_pkg::pc_t        cmd_next_pc;
    fetch_pkg::jump_flag_t cmd_jump_flag;
    logic                  cmd_miss;
    fetch_pkg::history_t   cmd_history;
    logic                  mem_valid;
    logic                  mem_ready;
    fetch_pkg::pc_t        mem_addr;
    logic                  jump_valid;
    fetch_pkg::pc_t        jump_current_pc;
    fetch_pkg::pc_t        jump_actual_next_pc;
    logic                  jump_update_pc;
    logic                  jump_jumped;
    logic                  jump_branched;
    logic                  jump_miss;
    fetch_pkg::history_t   jump_history;

    integer seed;

    // Reference copy of the target table
    fetch_pkg::btb_tag_t m_tag    [entries];
    fetch_pkg::pc_t      m_target [entries];
    logic                m_jumped [entries];
    fetch_pkg::history_t m_hist   [entries];
    logic [entries-1:0]  m_entry_valid;

    // Reference stage state with valid bit 1 for the command and bit 0 for the memory request
    logic [1:0]            m_valid;
    fetch_pkg::pc_t        m_pc;
    fetch_pkg::jump_flag_t m_flag;
    logic                  m_miss;
    fetch_pkg::history_t   m_cmd_hist;

    // Accepted commands that come back later as jumps
    fetch_pkg::pc_t      acc_pc   [$];
    logic                acc_miss [$];
    fetch_pkg::history_t acc_hist [$];

    int num_accepted;

    fetch_top #(
        .start_addr (start_addr)
    ) DUT (
        .clk                 (clk),
        .rst                 (rst),
        .cmd_valid           (cmd_valid),
        .cmd_ready           (cmd_ready),
        .cmd_pc              (cmd_pc),
        .cmd_next_pc         (cmd_next_pc),
        .cmd_jump_flag       (cmd_jump_flag),
        .cmd_miss            (cmd_miss),
        .cmd_history         (cmd_history),
        .mem_valid           (mem_valid),
        .mem_ready           (mem_ready),
        .mem_addr            (mem_addr),
        .jump_valid          (jump_valid),
        .jump_current_pc     (jump_current_pc),
        .jump_actual_next_pc (jump_actual_next_pc),
        .jump_update_pc      (jump_update_pc),
        .jump_jumped         (jump_jumped),
        .jump_branched       (jump_branched),
        .jump_miss           (jump_miss),
        .jump_history        (jump_history)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic fetch_pkg::btb_index_t index_of(input fetch_pkg::pc_t pc);
        return pc[`FETCH_BTB_INDEX_WIDTH+1:2];
    endfunction

    function automatic fetch_pkg::btb_tag_t tag_of(input fetch_pkg::pc_t pc);
        return pc[`FETCH_PC_WIDTH-1:`FETCH_BTB_INDEX_WIDTH+2];
    endfunction

    function automatic logic model_hit(input fetch_pkg::pc_t pc);
        return m_entry_valid[index_of(pc)] && (m_tag[index_of(pc)] == tag_of(pc));
    endfunction

    // Stored target on a taken hit or else the next word
    function automatic fetch_pkg::pc_t predict_next(input fetch_pkg::pc_t pc);
        fetch_pkg::btb_index_t i;
        i = index_of(pc);
        if (model_hit(pc) && (m_jumped[i] || m_hist[i] == fetch_pkg::strong_taken ||
                m_hist[i] == fetch_pkg::taken)) begin
            return m_target[i];
        end
        return pc + 32'd4;
    endfunction

    function automatic fetch_pkg::history_t new_history(
        input logic                miss,
        input logic                branched,
        input fetch_pkg::history_t old
    );
        if (miss) begin
            return branched ? fetch_pkg::taken : fetch_pkg::not_taken;
        end
        if (branched) begin
            return (old == fetch_pkg::strong_not_taken) ? fetch_pkg::not_taken
                                                        : fetch_pkg::strong_taken;
        end
        return (old == fetch_pkg::strong_taken) ? fetch_pkg::taken
                                                : fetch_pkg::strong_not_taken;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
        $display("sim failed");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic check_pc(input string name, input fetch_pkg::pc_t exp,
                            input fetch_pkg::pc_t got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic check_flag(input fetch_pkg::jump_flag_t exp, input fetch_pkg::jump_flag_t got);
        if (got !== exp) report_mismatch("cmd_jump_flag", exp, got);
    endtask

    task automatic check_history(input fetch_pkg::history_t exp, input fetch_pkg::history_t got);
        if (got !== exp) report_mismatch("cmd_history", exp, got);
    endtask

    task automatic check_cmd(input fetch_pkg::pc_t pc, input fetch_pkg::pc_t next_pc,
                             input fetch_pkg::jump_flag_t flag, input logic miss,
                             input fetch_pkg::history_t hist);
        check_pc("cmd_pc", pc, cmd_pc);
        check_pc("cmd_next_pc", next_pc, cmd_next_pc);
        check_flag(flag, cmd_jump_flag);
        check_bit("cmd_miss", miss, cmd_miss);
        check_history(hist, cmd_history);
    endtask

    task automatic check_mem(input fetch_pkg::pc_t addr);
        check_pc("mem_addr", addr, mem_addr);
    endtask

    task automatic model_reset();
        m_valid       = 2'b00;
        m_pc          = start_addr - 32'd4;
        m_flag        = '0;
        m_entry_valid = '0;
    endtask

    // One clock edge of the reference on the inputs held before it
    task automatic model_step();
        fetch_pkg::btb_index_t wi;
        fetch_pkg::history_t   hist;
        fetch_pkg::pc_t        nxt;
        logic                  hit;
        logic                  en;
        hit  = model_hit(m_pc);
        // Missed lookups report a not-taken counter
        hist = hit ? m_hist[index_of(m_pc)] : fetch_pkg::strong_not_taken;
        nxt  = predict_next(m_pc);
        en   = (!m_valid[1] || cmd_ready) && (!m_valid[0] || mem_ready);
        if (m_valid[1] && cmd_ready) begin
            num_accepted++;
            if (acc_pc.size() < 8) begin
                acc_pc.push_back(m_pc);
                acc_miss.push_back(m_miss);
                acc_hist.push_back(m_cmd_hist);
            end
        end
        if (jump_valid) begin
            wi                = index_of(jump_current_pc);
            m_tag[wi]         = tag_of(jump_current_pc);
            m_target[wi]      = jump_actual_next_pc;
            m_jumped[wi]      = jump_jumped;
            m_hist[wi]        = new_history(jump_miss, jump_branched, jump_history);
            m_entry_valid[wi] = 1'b1;
        end
        if (jump_valid && jump_update_pc) begin
            m_pc   = jump_actual_next_pc;
            m_flag = m_flag + 2'd1;
        end else if (en) begin
            m_pc = nxt;
        end
        if (en) begin
            m_miss     = !hit;
            m_cmd_hist = hist;
            m_valid    = 2'b11;
        end else begin
            m_valid = m_valid & ~{cmd_ready, mem_ready};
        end
    endtask

    task automatic check_outputs();
        check_bit("cmd_valid", m_valid[1], cmd_valid);
        check_bit("mem_valid", m_valid[0], mem_valid);
        if (m_valid[1]) check_cmd(m_pc, predict_next(m_pc), m_flag, m_miss, m_cmd_hist);
        if (m_valid[0]) check_mem(m_pc);
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] t;
        r          = $random(seed);
        t          = $random(seed);
        cmd_ready  = r[0] | r[1];
        mem_ready  = r[2] | r[3];
        jump_valid = 1'b0;
        if (acc_pc.size() > 0 && r[5:4] == 2'b00) begin
            jump_valid      = 1'b1;
            jump_current_pc = acc_pc.pop_front();
            jump_miss       = acc_miss.pop_front();
            jump_history    = acc_hist.pop_front();
            jump_branched   = r[6];
            jump_jumped     = r[7] & r[8];
            jump_update_pc  = r[9];
            // Low targets keep pcs inside a few tags per index
            jump_actual_next_pc = t & 32'h0000_01fc;
        end
    endtask

    task automatic check_progress();
        if (num_accepted < num_cycles / 8) begin
            $display("Too few commands were transferred during the run");
            $display("sim failed");
            $fatal(1, "no progress");
        end
    endtask

    initial begin
        seed                = 57108;
        num_accepted        = 0;
        rst                 = 1'b1;
        cmd_ready           = 1'b0;
        mem_ready           = 1'b0;
        jump_valid          = 1'b0;
        jump_current_pc     = '0;
        jump_actual_next_pc = '0;
        jump_update_pc      = 1'b0;
        jump_jumped         = 1'b0;
        jump_branched       = 1'b0;
        jump_miss           = 1'b0;
        jump_history        = fetch_pkg::strong_not_taken;
        model_reset();
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        check_outputs();
        drive_inputs();
        for (int cycle = 0; cycle < num_cycles; cycle++) begin
            @(posedge clk);
            #5;
            model_step();
            check_outputs();
            drive_inputs();
        end
        @(posedge clk);
        #5;
        model_step();
        check_outputs();
        check_progress();
        $display("sim passed");
        $finish;
    end

    initial begin
        #(num_cycles * 40 * 4);
        $display("Watchdog expired before the test sequence finished");
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
